// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int xlen = 64;
    localparam int inst_width = 32;
    localparam int lane_count = 8;

    // access width as encoded by the core.
    typedef enum logic [1:0] {
        width_b = 2'd0,
        width_h = 2'd1,
        width_w = 2'd2,
        width_d = 2'd3
    } mem_width_e;

    typedef struct packed {
        logic [xlen-1:0] addr;
        mem_width_e      width;
        logic            is_signed;
    } load_req_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        mem_width_e      width;
        logic [xlen-1:0] data;
    } store_req_t;

    // what the extract stage needs to cut the returned word.
    typedef struct packed {
        logic [2:0] offset;
        mem_width_e width;
        logic       is_signed;
    } load_tag_t;

    typedef struct packed {
        logic [xlen-4:0]       index;
        logic [xlen-1:0]       data;
        logic [lane_count-1:0] byte_en;
    } ram_wr_t;

endpackage

`default_nettype wire

// ==== hdl/key_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_mux #(
    parameter int  nr_key    = 2,
    parameter int  key_len   = 1,
    parameter type payload_t = logic [63:0]
) (
    input  logic [key_len-1:0]                          key,
    input  logic [nr_key*(key_len+$bits(payload_t))-1:0] lut,
    input  payload_t                                    default_out,
    output payload_t                                    out
);

    localparam int payload_len = $bits(payload_t);
    localparam int pair_len = key_len + payload_len;

    // pair i sits at bits [i*pair_len +: pair_len], key on top.
    always_comb begin
        logic [pair_len-1:0] pair;
        out = default_out;
        for (int i = 0; i < nr_key; i++) begin
            pair = lut[i*pair_len +: pair_len];
            if (pair[pair_len-1 -: key_len] == key) begin
                out = payload_t'(pair[payload_len-1:0]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  mem_pkg::store_req_t               store_req,
    output logic [mem_pkg::lane_count-1:0]    store_byte_en,
    output logic [mem_pkg::xlen-1:0]          store_lane_data
);
    import mem_pkg::*;

    logic [2:0]            offset;
    logic [lane_count-1:0] base_mask;

    assign offset = store_req.addr[2:0];

    // replicate the low bytes so the addressed lanes carry them.
    always_comb begin
        case (store_req.width)
            width_b: store_lane_data = {lane_count{store_req.data[7:0]}};
            width_h: store_lane_data = {(lane_count / 2){store_req.data[15:0]}};
            width_w: store_lane_data = {(lane_count / 4){store_req.data[31:0]}};
            default: store_lane_data = store_req.data;
        endcase
    end

    always_comb begin
        case (store_req.width)
            width_b: base_mask = 8'h01;
            width_h: base_mask = 8'h03;
            width_w: base_mask = 8'h0f;
            default: base_mask = 8'hff;
        endcase
    end

    // misaligned shifts lose bits, but those stores never reach the ram.
    assign store_byte_en = base_mask << offset;

endmodule

`default_nettype wire

// ==== hdl/load_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_extract (
    input  logic [mem_pkg::xlen-1:0] rd_word,
    input  mem_pkg::load_tag_t       load_tag,
    output logic [mem_pkg::xlen-1:0] load_data
);
    import mem_pkg::*;

    typedef logic [xlen-1:0] dword_t;

    localparam int off_pair = 3 + xlen;
    localparam int wdt_pair = 2 + xlen;

    logic [8*off_pair-1:0] byte_lut;
    logic [4*off_pair-1:0] half_lut;
    logic [2*off_pair-1:0] word_lut;
    logic [4*wdt_pair-1:0] width_lut;
    dword_t                byte_val;
    dword_t                half_val;
    dword_t                word_val;

    genvar i;

    // each lane extended by its own top bit when signed.
    generate
        for (i = 0; i < 8; i++) begin : g_byte
            logic [7:0] lane;
            assign lane = rd_word[i*8 +: 8];
            assign byte_lut[i*off_pair +: off_pair] =
                {3'(i), {(xlen - 8){load_tag.is_signed & lane[7]}}, lane};
        end
        for (i = 0; i < 4; i++) begin : g_half
            logic [15:0] lane;
            assign lane = rd_word[i*16 +: 16];
            assign half_lut[i*off_pair +: off_pair] =
                {3'(2 * i), {(xlen - 16){load_tag.is_signed & lane[15]}}, lane};
        end
        for (i = 0; i < 2; i++) begin : g_word
            logic [31:0] lane;
            assign lane = rd_word[i*32 +: 32];
            assign word_lut[i*off_pair +: off_pair] =
                {3'(4 * i), {(xlen - 32){load_tag.is_signed & lane[31]}}, lane};
        end
    endgenerate

    assign width_lut = {
        width_d, rd_word,
        width_w, word_val,
        width_h, half_val,
        width_b, byte_val
    };

    key_mux #(.nr_key(8), .key_len(3), .payload_t(dword_t)) u_byte_mux (
        .key         (load_tag.offset),
        .lut         (byte_lut),
        .default_out ('0),
        .out         (byte_val)
    );

    // odd offsets fault upstream, so they fall to the default.
    key_mux #(.nr_key(4), .key_len(3), .payload_t(dword_t)) u_half_mux (
        .key         (load_tag.offset),
        .lut         (half_lut),
        .default_out ('0),
        .out         (half_val)
    );

    key_mux #(.nr_key(2), .key_len(3), .payload_t(dword_t)) u_word_mux (
        .key         (load_tag.offset),
        .lut         (word_lut),
        .default_out ('0),
        .out         (word_val)
    );

    key_mux #(.nr_key(4), .key_len(2), .payload_t(dword_t)) u_width_mux (
        .key         (load_tag.width),
        .lut         (width_lut),
        .default_out (rd_word),
        .out         (load_data)
    );

endmodule

`default_nettype wire

// ==== hdl/mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl #(
    parameter int mem_words = 512
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 load_en,
    input  mem_pkg::load_req_t                   load_req,
    input  logic                                 store_en,
    input  mem_pkg::store_req_t                  store_req,
    input  logic [mem_pkg::lane_count-1:0]       store_byte_en,
    input  logic [mem_pkg::xlen-1:0]             store_lane_data,
    output logic                                 ram_ren,
    output logic [$clog2(mem_words)-1:0]         ram_rd_index,
    output logic                                 ram_wen,
    output mem_pkg::ram_wr_t                     ram_wr,
    output mem_pkg::load_tag_t                   load_tag,
    output logic                                 load_valid,
    output logic                                 load_fault,
    output logic                                 store_fault
);
    import mem_pkg::*;

    localparam int index_bits = $clog2(mem_words);
    localparam logic [xlen-4:0] index_mask = (xlen - 3)'(mem_words - 1);

    logic load_aligned;
    logic store_aligned;

    // natural alignment means the offset bits below the access size are zero.
    function automatic logic is_aligned(logic [2:0] offset, mem_width_e width);
        logic [2:0] low_mask;
        case (width)
            width_b: low_mask = 3'b000;
            width_h: low_mask = 3'b001;
            width_w: low_mask = 3'b011;
            default: low_mask = 3'b111;
        endcase
        return (offset & low_mask) == 3'b000;
    endfunction

    assign load_aligned = is_aligned(load_req.addr[2:0], load_req.width);
    assign store_aligned = is_aligned(store_req.addr[2:0], store_req.width);

    assign ram_ren = load_en & load_aligned;
    assign ram_rd_index = load_req.addr[3 +: index_bits];

    // store goes to the ram at the same edge it is sampled.
    assign ram_wen = store_en & store_aligned;
    assign ram_wr.index = store_req.addr[xlen-1:3] & index_mask;
    assign ram_wr.data = store_lane_data;
    assign ram_wr.byte_en = store_byte_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_valid <= 1'b0;
            load_fault <= 1'b0;
            store_fault <= 1'b0;
        end else begin
            load_valid <= load_en & load_aligned;
            load_fault <= load_en & ~load_aligned;
            store_fault <= store_en & ~store_aligned;
        end
    end

    // tag lines up with the registered ram read.
    always_ff @(posedge clk) begin
        if (load_en) begin
            load_tag.offset <= load_req.addr[2:0];
            load_tag.width <= load_req.width;
            load_tag.is_signed <= load_req.is_signed;
        end
    end

    a_valid_fault_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load_valid && load_fault)
    ) else $error("load_valid and load_fault high together");

    // mask comes from store_align.
    a_wen_has_lanes: assert property (
        @(posedge clk) disable iff (!rst_n)
        ram_wen |-> (|ram_wr.byte_en)
    ) else $error("ram write with empty byte enable");

endmodule

`default_nettype wire

// ==== hdl/word_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int mem_words = 512
) (
    input  logic                          clk,
    input  logic [$clog2(mem_words)-1:0]  fetch_index,
    output logic [mem_pkg::xlen-1:0]      fetch_word,
    input  logic                          ram_ren,
    input  logic [$clog2(mem_words)-1:0]  ram_rd_index,
    output logic [mem_pkg::xlen-1:0]      rd_word,
    input  logic                          ram_wen,
    input  mem_pkg::ram_wr_t              ram_wr
);
    import mem_pkg::*;

    localparam int index_bits = $clog2(mem_words);

    logic [xlen-1:0]       mem [mem_words];
    logic [index_bits-1:0] wr_index;

    assign wr_index = ram_wr.index[index_bits-1:0];

    // fetch sees the array directly.
    assign fetch_word = mem[fetch_index];

    // read-before-write: a same-edge store is not visible to rd_word.
    always_ff @(posedge clk) begin
        if (ram_ren) begin
            rd_word <= mem[ram_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (ram_wen) begin
            for (int i = 0; i < lane_count; i++) begin
                if (ram_wr.byte_en[i]) begin
                    mem[wr_index][i*8 +: 8] <= ram_wr.data[i*8 +: 8];
                end
            end
        end
    end

    a_wr_in_range: assert property (
        @(posedge clk)
        ram_wen |-> (ram_wr.index < (xlen - 3)'(mem_words))
    ) else $error("write index beyond ram depth");

endmodule

`default_nettype wire

// ==== hdl/mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_top #(
    parameter int mem_words = 512
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [mem_pkg::xlen-1:0]          pc,
    output logic [mem_pkg::inst_width-1:0]    inst,
    input  logic                              load_en,
    input  mem_pkg::load_req_t                load_req,
    output logic [mem_pkg::xlen-1:0]          load_data,
    output logic                              load_valid,
    output logic                              load_fault,
    input  logic                              store_en,
    input  mem_pkg::store_req_t               store_req,
    output logic                              store_fault
);
    import mem_pkg::*;

    localparam int index_bits = $clog2(mem_words);

    logic                  ram_ren;
    logic [index_bits-1:0] ram_rd_index;
    logic                  ram_wen;
    ram_wr_t               ram_wr;
    logic [xlen-1:0]       rd_word;
    logic [xlen-1:0]       fetch_word;
    load_tag_t             load_tag;
    logic [lane_count-1:0] store_byte_en;
    logic [xlen-1:0]       store_lane_data;

    mem_ctrl #(.mem_words(mem_words)) u_mem_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .load_en         (load_en),
        .load_req        (load_req),
        .store_en        (store_en),
        .store_req       (store_req),
        .store_byte_en   (store_byte_en),
        .store_lane_data (store_lane_data),
        .ram_ren         (ram_ren),
        .ram_rd_index    (ram_rd_index),
        .ram_wen         (ram_wen),
        .ram_wr          (ram_wr),
        .load_tag        (load_tag),
        .load_valid      (load_valid),
        .load_fault      (load_fault),
        .store_fault     (store_fault)
    );

    word_ram #(.mem_words(mem_words)) u_word_ram (
        .clk          (clk),
        .fetch_index  (pc[3 +: index_bits]),
        .fetch_word   (fetch_word),
        .ram_ren      (ram_ren),
        .ram_rd_index (ram_rd_index),
        .rd_word      (rd_word),
        .ram_wen      (ram_wen),
        .ram_wr       (ram_wr)
    );

    store_align u_store_align (
        .store_req       (store_req),
        .store_byte_en   (store_byte_en),
        .store_lane_data (store_lane_data)
    );

    load_extract u_load_extract (
        .rd_word   (rd_word),
        .load_tag  (load_tag),
        .load_data (load_data)
    );

    // pc bit 2 picks the instruction half.
    key_mux #(
        .nr_key    (2),
        .key_len   (1),
        .payload_t (logic [inst_width-1:0])
    ) u_fetch_mux (
        .key         (pc[2]),
        .lut         ({1'b1, fetch_word[63:32], 1'b0, fetch_word[31:0]}),
        .default_out (fetch_word[31:0]),
        .out         (inst)
    );

endmodule

`default_nettype wire

// ==== dv/tb_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_top;
    import mem_pkg::*;

    localparam int mem_words = 512;
    localparam int mem_bytes = mem_words * 8;
    localparam int byte_bits = $clog2(mem_bytes);
    localparam int region_words = 16;
    localparam int random_cycles = 300;
    // reset, region fill, directed tests, random run and drains.
    localparam int test_cycles = 2 + region_words + 80 + random_cycles + 12;
    localparam int margin_cycles = 100;

    logic                  clk;
    logic                  rst_n;
    logic [xlen-1:0]       pc;
    logic [inst_width-1:0] inst;
    logic                  load_en;
    load_req_t             load_req;
    logic [xlen-1:0]       load_data;
    logic                  load_valid;
    logic                  load_fault;
    logic                  store_en;
    store_req_t            store_req;
    logic                  store_fault;

    logic [7:0]      model [mem_bytes];
    logic            exp_valid;
    logic            exp_fault;
    logic            exp_sfault;
    logic [xlen-1:0] exp_data;
    logic            fetch_live;
    logic [31:0]     rng_state;
    int              err_count;
    int              err_at_start;
    int              tests_passed;
    int              tests_failed;

    mem_top #(.mem_words(mem_words)) u_mem_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (pc),
        .inst        (inst),
        .load_en     (load_en),
        .load_req    (load_req),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .load_fault  (load_fault),
        .store_en    (store_en),
        .store_req   (store_req),
        .store_fault (store_fault)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic int access_bytes(mem_width_e width);
        return 1 << int'(width);
    endfunction

    function automatic logic aligned(logic [xlen-1:0] addr, mem_width_e width);
        return (int'(addr[2:0]) % access_bytes(width)) == 0;
    endfunction

    // little endian bytes wrapped to the memory size.
    function automatic logic [xlen-1:0] model_load(logic [xlen-1:0] addr, mem_width_e width,
                                                   logic is_signed);
        int              base;
        int              n;
        logic [xlen-1:0] value;
        base = int'(addr[byte_bits-1:0]);
        n = access_bytes(width);
        value = '0;
        for (int k = 0; k < n; k++) begin
            value[8*k +: 8] = model[base + k];
        end
        if (is_signed && value[8*n-1]) begin
            for (int b = 8 * n; b < xlen; b++) begin
                value[b] = 1'b1;
            end
        end
        return value;
    endfunction

    function automatic logic [inst_width-1:0] model_inst(logic [xlen-1:0] addr);
        int base;
        base = int'({addr[byte_bits-1:2], 2'b00});
        return {model[base + 3], model[base + 2], model[base + 1], model[base]};
    endfunction

    task automatic model_write(logic [xlen-1:0] addr, mem_width_e width, logic [xlen-1:0] data);
        int base;
        base = int'(addr[byte_bits-1:0]);
        for (int k = 0; k < access_bytes(width); k++) begin
            model[base + k] = data[8*k +: 8];
        end
    endtask

    function automatic logic [xlen-1:0] fill_word(logic [xlen-1:0] addr);
        return (addr * 64'h9e37_79b9_7f4a_7c15) ^ {addr[31:0], addr[63:32]};
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // high bits alias onto the region and low bits pick word and offset.
    function automatic logic [xlen-1:0] place_addr(logic [31:0] hi, logic [3:0] word,
                                                   logic [2:0] off, mem_width_e width,
                                                   logic misalign);
        logic [xlen-1:0] a;
        a = {hi, 32'h0};
        a[6:3] = word;
        a[2:0] = misalign ? off : (off & ~3'(access_bytes(width) - 1));
        return a;
    endfunction

    // a load sees the model as it was before a same-edge store.
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_valid <= 1'b0;
            exp_fault <= 1'b0;
            exp_sfault <= 1'b0;
        end else begin
            exp_valid <= load_en && aligned(load_req.addr, load_req.width);
            exp_fault <= load_en && !aligned(load_req.addr, load_req.width);
            if (load_en && aligned(load_req.addr, load_req.width)) begin
                exp_data <= model_load(load_req.addr, load_req.width, load_req.is_signed);
            end
            exp_sfault <= store_en && !aligned(store_req.addr, store_req.width);
            if (store_en && aligned(store_req.addr, store_req.width)) begin
                model_write(store_req.addr, store_req.width, store_req.data);
            end
        end
    end

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
        err_count++;
    endtask

    a_load_valid: assert property (@(negedge clk) disable iff (!rst_n)
        load_valid == exp_valid)
        else report_mismatch("load_valid", 64'(exp_valid), 64'(load_valid));

    a_load_fault: assert property (@(negedge clk) disable iff (!rst_n)
        load_fault == exp_fault)
        else report_mismatch("load_fault", 64'(exp_fault), 64'(load_fault));

    a_store_fault: assert property (@(negedge clk) disable iff (!rst_n)
        store_fault == exp_sfault)
        else report_mismatch("store_fault", 64'(exp_sfault), 64'(store_fault));

    a_load_data: assert property (@(negedge clk) disable iff (!rst_n)
        exp_valid |-> load_data == exp_data)
        else report_mismatch("load_data", exp_data, load_data);

    a_inst: assert property (@(negedge clk) disable iff (!fetch_live)
        inst == model_inst(pc))
        else report_mismatch("inst", 64'(model_inst(pc)), 64'(inst));

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic do_store(logic [xlen-1:0] addr, mem_width_e width, logic [xlen-1:0] data);
        store_en = 1'b1;
        store_req = '{addr: addr, width: width, data: data};
        next_cycle();
        store_en = 1'b0;
    endtask

    task automatic do_load(logic [xlen-1:0] addr, mem_width_e width, logic is_signed);
        load_en = 1'b1;
        load_req = '{addr: addr, width: width, is_signed: is_signed};
        next_cycle();
        load_en = 1'b0;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [3:0]  lw;
        logic [3:0]  sw;
        r = next_random();
        r2 = next_random();
        r3 = next_random();
        load_en = r[0];
        store_en = r[1];
        load_req.width = mem_width_e'(r[3:2]);
        load_req.is_signed = r[4];
        store_req.width = mem_width_e'(r[6:5]);
        lw = r[10:7];
        sw = (r[12:11] == 2'd0) ? lw : r[16:13];
        load_req.addr = place_addr(r2, lw, r[19:17], load_req.width, r[22:20] == 3'd0);
        store_req.addr = place_addr(~r2, sw, r[25:23], store_req.width, r[28:26] == 3'd0);
        store_req.data = {r3, r2 ^ r};
        pc = {r2, 25'h0, r3[6:0]};
    endtask

    task automatic begin_test();
        err_at_start = err_count;
    endtask

    task automatic finish_test(string name);
        load_en = 1'b0;
        store_en = 1'b0;
        next_cycle();
        next_cycle();
        if (err_count == err_at_start) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, err_count - err_at_start);
        end
    endtask

    initial begin
        #((test_cycles + margin_cycles) * 40);
        $display("watchdog expired after %0d cycles, run did not finish",
                 test_cycles + margin_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        pc = '0;
        load_en = 1'b0;
        load_req = '0;
        store_en = 1'b0;
        store_req = '0;
        fetch_live = 1'b0;
        rng_state = 32'h0b68179c;
        err_count = 0;
        err_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < mem_bytes; i++) begin
            model[i] = 8'h00;
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // fill the working region so fetches and loads see known data.
        for (int w = 0; w < region_words; w++) begin
            do_store(64'(w * 8), width_d, fill_word(64'(w * 8)));
        end
        fetch_live = 1'b1;

        begin_test();
        do_store(64'h40, width_d, 64'h8877_6655_4433_2211);
        do_load(64'h40, width_d, 1'b0);
        finish_test("double store and load");

        begin_test();
        do_store(64'h48, width_d, 64'h7f80_0172_ff01_8e6c);
        for (int s = 0; s < 2; s++) begin
            for (int o = 0; o < 8; o++) begin
                do_load(64'h48 + 64'(o), width_b, 1'(s));
            end
            for (int o = 0; o < 8; o += 2) begin
                do_load(64'h48 + 64'(o), width_h, 1'(s));
            end
            for (int o = 0; o < 8; o += 4) begin
                do_load(64'h48 + 64'(o), width_w, 1'(s));
            end
        end
        finish_test("sub-word loads");

        begin_test();
        do_store(64'h50, width_d, 64'h1111_2222_3333_4444);
        do_store(64'h53, width_b, 64'hdead_beef_cafe_12a5);
        do_store(64'h56, width_h, 64'h0123_4567_89ab_5a6b);
        do_store(64'h58, width_w, 64'hffff_0000_c001_d00d);
        do_load(64'h50, width_d, 1'b0);
        do_load(64'h58, width_d, 1'b0);
        finish_test("partial stores");

        begin_test();
        do_store(64'h60, width_d, 64'hcafe_f00d_1234_5678);
        pc = 64'h60;
        next_cycle();
        pc = 64'h64;
        next_cycle();
        do_store(64'h64, width_w, 64'h0000_0000_0bad_c0de);
        next_cycle();
        pc = 64'h62;
        do_store(64'h60, width_h, 64'h9abc);
        next_cycle();
        finish_test("fetch halves");

        begin_test();
        do_load(64'h41, width_h, 1'b0);
        do_load(64'h42, width_w, 1'b1);
        do_load(64'h44, width_d, 1'b0);
        do_store(64'h44, width_d, 64'h5555_5555_5555_5555);
        do_store(64'h4a, width_w, 64'h6666_6666);
        do_store(64'h4f, width_h, 64'h7777);
        do_load(64'h40, width_d, 1'b0);
        do_load(64'h48, width_d, 1'b0);
        finish_test("misaligned accesses");

        begin_test();
        for (int c = 0; c < random_cycles; c++) begin
            drive_random();
            next_cycle();
        end
        finish_test("random traffic");

        $display("tests passed %0d failed %0d, %0d errors", tests_passed, tests_failed,
                 err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/mem_pkg.sv
hdl/key_mux.sv
hdl/store_align.sv
hdl/load_extract.sv
hdl/mem_ctrl.sv
hdl/word_ram.sv
hdl/mem_top.sv
dv/tb_mem_top.sv

// ==== Makefile ====
SIM_BIN := obj_dir/Vtb_mem_top
SRCS := $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: run

$(SIM_BIN): tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_top -f tb.f

run: $(SIM_BIN)
	@out=$$(./$(SIM_BIN)); echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf obj_dir
